/* sim/xcorr_model.svh */
// reference correlation model
// accepted sample history and per-tag delivery counts

`ifndef XCORR_MODEL_SVH
`define XCORR_MODEL_SVH

// every sample taken by the FIFO, in order
xcorr_pkg::sample_t accepted_q [$];
// results already checked, per tag
int                 delivered [NUM_TAGS];

task automatic model_accept(input xcorr_pkg::sample_t value);
  accepted_q.push_back(value);
endtask

// signed sum of the last TAPS samples up to index, zeros before the first
function automatic xcorr_pkg::result_t expected_result(input int tag, input int index);
  int acc;
  int s;
  acc = 0;
  for (int i = 0; i < xcorr_pkg::TAPS; i++) begin
    if (index - i >= 0) begin
      s = accepted_q[index - i];
    end else begin
      s = 0;
    end
    if (xcorr_pkg::tag_templates[tag][i]) begin
      acc = acc - s;
    end else begin
      acc = acc + s;
    end
  end
  return xcorr_pkg::result_t'(acc);
endfunction

// results still owed by the enabled tags
function automatic int outstanding();
  int total;
  total = 0;
  for (int t = 0; t < NUM_TAGS; t++) begin
    if (TAG_ENABLE[t]) begin
      total = total + accepted_q.size() - delivered[t];
    end
  end
  return total;
endfunction

`endif

/* sim/tb_xcorr.sv */
// cross-correlation front end testbench

`timescale 1ns/1ps
`default_nettype none

module tb_xcorr;

  localparam int                  NUM_TAGS = 4;
  localparam int                  FIFO_DEPTH = 16;
  localparam logic [NUM_TAGS-1:0] TAG_ENABLE = 4'b1011;

  logic                              in_clk = 1'b0;
  logic                              clk = 1'b0;
  logic                              rst_n;
  logic                              s_valid;
  logic                              s_ready;
  xcorr_pkg::sample_t                s_data;
  logic [NUM_TAGS-1:0]               m_valid;
  logic [NUM_TAGS-1:0]               m_ready;
  xcorr_pkg::result_t [NUM_TAGS-1:0] m_data;

  integer seed = 64661;
  // 0 all ready, 1 random per tag, 2 all stalled
  int     ready_mode = 0;
  string  test_name = "reset";

  `include "xcorr_model.svh"

  xcorr_top #(
    .NUM_TAGS   (NUM_TAGS),
    .FIFO_DEPTH (FIFO_DEPTH),
    .TAG_ENABLE (TAG_ENABLE)
  ) xcorr_top_i (
    .in_clk  (in_clk),
    .clk     (clk),
    .rst_n   (rst_n),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data)
  );

  always #4 clk = ~clk;

  // write clock starts 3 ns late
  always begin
    #3;
    forever #4 in_clk = ~in_clk;
  end

  task automatic stop_on_failure(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_result(input int tag, input xcorr_pkg::result_t actual);
    xcorr_pkg::result_t expected;
    assert (delivered[tag] < accepted_q.size()) else
      stop_on_failure($sformatf("tag %0d delivered a result with no sample pending", tag));
    expected = expected_result(tag, delivered[tag]);
    delivered[tag]++;
    assert (actual == expected) else
      stop_on_failure($sformatf("error %s tag %0d expected %0d actual %0d",
                                test_name, tag, expected, actual));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // monitors and output ready driver
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge in_clk) begin
    if (rst_n && s_valid && s_ready) begin
      model_accept(s_data);
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      for (int t = 0; t < NUM_TAGS; t++) begin
        if (TAG_ENABLE[t]) begin
          if (m_valid[t] && m_ready[t]) begin
            check_result(t, m_data[t]);
          end
        end else begin
          assert (!m_valid[t] && m_data[t] == '0) else
            stop_on_failure($sformatf("disabled tag %0d produced output", t));
        end
      end
    end
  end

  always @(negedge clk) begin
    case (ready_mode)
      1: m_ready = $random(seed);
      2: m_ready = '0;
      default: m_ready = '1;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus tasks, all called on a falling in_clk edge
  ////////////////////////////////////////////////////////////////////////////

  // s_ready is stable between rising edges, so the falling edge sees it
  task automatic complete_transfer();
    int waited;
    waited = 0;
    while (!s_ready) begin
      @(negedge in_clk);
      waited++;
      assert (waited < 500) else
        stop_on_failure($sformatf("%s: s_ready stayed low with a sample waiting", test_name));
    end
    @(negedge in_clk);
    s_valid = 1'b0;
  endtask

  task automatic send_burst(input int count);
    @(negedge in_clk);
    for (int n = 0; n < count; n++) begin
      s_valid = 1'b1;
      s_data = xcorr_pkg::sample_t'($random(seed));
      complete_transfer();
      if (($random(seed) & 3) == 0) begin
        @(negedge in_clk);
      end
    end
  endtask

  task automatic wait_drain(input int limit);
    int waited;
    waited = 0;
    while (outstanding() != 0) begin
      @(negedge clk);
      waited++;
      assert (waited < limit) else
        stop_on_failure($sformatf("%s: results still missing after %0d cycles",
                                  test_name, limit));
    end
  endtask

  initial begin
    int waited;
    rst_n = 1'b0;
    s_valid = 1'b0;
    s_data = '0;
    m_ready = '1;
    for (int t = 0; t < NUM_TAGS; t++) begin
      delivered[t] = 0;
    end

    repeat (8) begin
      @(negedge clk);
      assert (m_valid == '0) else stop_on_failure("m_valid high during reset");
    end
    rst_n = 1'b1;
    repeat (2) begin
      @(negedge clk);
      assert (m_valid == '0) else stop_on_failure("m_valid high right after reset");
    end

    waited = 0;
    @(negedge in_clk);
    while (!s_ready) begin
      @(negedge in_clk);
      waited++;
      assert (waited < 20) else stop_on_failure("s_ready did not rise after reset");
    end

    test_name = "steady";
    ready_mode = 0;
    send_burst(60);
    wait_drain(1000);

    test_name = "random_ready";
    ready_mode = 1;
    send_burst(200);
    wait_drain(4000);

    // stall every output and keep streaming until the FIFO is full
    test_name = "fifo_full";
    ready_mode = 2;
    @(negedge in_clk);
    s_valid = 1'b1;
    s_data = xcorr_pkg::sample_t'($random(seed));
    waited = 0;
    while (s_ready) begin
      @(negedge in_clk);
      s_data = xcorr_pkg::sample_t'($random(seed));
      waited++;
      assert (waited < 200) else stop_on_failure("s_ready never fell with outputs stalled");
    end
    repeat (16) begin
      @(negedge in_clk);
      assert (!s_ready) else stop_on_failure("s_ready rose while outputs were stalled");
    end
    ready_mode = 0;
    complete_transfer();
    wait_drain(2000);

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

/* source/sample_fifo_async.sv */
// dual-clock sample FIFO
// gray pointers, first-word fall-through read

`timescale 1ns/1ps
`default_nettype none

module sample_fifo_async #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic               in_clk,
  input  logic               clk,
  input  logic               rst_n,

  input  logic               wr_valid,
  output logic               wr_ready,
  input  xcorr_pkg::sample_t wr_data,

  output logic               rd_valid,
  input  logic               rd_pop,
  output xcorr_pkg::sample_t rd_data
);

  localparam int AW = $clog2(FIFO_DEPTH);

  function automatic logic [AW:0] bin2gray(input logic [AW:0] b);
    return b ^ (b >> 1);
  endfunction

  xcorr_pkg::sample_t mem [FIFO_DEPTH];

  logic [AW:0] wr_bin;
  logic [AW:0] wr_gray;
  logic [AW:0] wr_bin_next;
  logic [AW:0] rd_bin;
  logic [AW:0] rd_gray;
  logic [AW:0] rd_bin_next;

  // pointers seen from the other domain
  logic [AW:0] rd_gray_w1;
  logic [AW:0] rd_gray_w2;
  logic [AW:0] wr_gray_r1;
  logic [AW:0] wr_gray_r2;

  logic        full;
  logic        empty;
  logic        do_write;
  logic        do_read;

  ////////////////////////////////////////////////////////////////////////////
  // write domain
  ////////////////////////////////////////////////////////////////////////////

  // full when the top two gray bits differ and the rest match
  assign full = (wr_gray == {~rd_gray_w2[AW:AW-1], rd_gray_w2[AW-2:0]});
  assign wr_ready = ~full;
  assign do_write = wr_valid & ~full;
  assign wr_bin_next = wr_bin + 1'b1;

  always_ff @(posedge in_clk) begin
    if (!rst_n) begin
      wr_bin <= '0;
      wr_gray <= '0;
    end else if (do_write) begin
      wr_bin <= wr_bin_next;
      wr_gray <= bin2gray(wr_bin_next);
    end
  end

  always_ff @(posedge in_clk) begin
    if (do_write) begin
      mem[wr_bin[AW-1:0]] <= wr_data;
    end
  end

  always_ff @(posedge in_clk) begin
    if (!rst_n) begin
      rd_gray_w1 <= '0;
      rd_gray_w2 <= '0;
    end else begin
      rd_gray_w1 <= rd_gray;
      rd_gray_w2 <= rd_gray_w1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read domain
  ////////////////////////////////////////////////////////////////////////////

  assign empty = (rd_gray == wr_gray_r2);
  assign rd_valid = ~empty;
  assign do_read = rd_pop & ~empty;
  assign rd_bin_next = rd_bin + 1'b1;
  assign rd_data = mem[rd_bin[AW-1:0]];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_bin <= '0;
      rd_gray <= '0;
    end else if (do_read) begin
      rd_bin <= rd_bin_next;
      rd_gray <= bin2gray(rd_bin_next);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_gray_r1 <= '0;
      wr_gray_r2 <= '0;
    end else begin
      wr_gray_r1 <= wr_gray;
      wr_gray_r2 <= wr_gray_r1;
    end
  end

endmodule

`default_nettype wire

/* source/xcorr_fanout_ctrl.sv */
// sample broadcast control

`timescale 1ns/1ps
`default_nettype none

module xcorr_fanout_ctrl #(
  parameter int                  NUM_TAGS = 4,
  parameter logic [NUM_TAGS-1:0] TAG_ENABLE = '1
) (
  input  logic                clk,
  input  logic                rst_n,

  input  logic                fifo_valid,
  output logic                fifo_pop,
  input  xcorr_pkg::sample_t  fifo_data,

  output logic [NUM_TAGS-1:0] bcast_valid,
  input  logic [NUM_TAGS-1:0] bcast_ready,
  output xcorr_pkg::sample_t  bcast_data
);

  // tags that have not yet taken the held sample
  logic [NUM_TAGS-1:0] pending;
  logic [NUM_TAGS-1:0] remaining;
  xcorr_pkg::sample_t  data_q;

  assign remaining = pending & ~bcast_ready;

  // next sample may load in the cycle the last tag takes the current one
  assign fifo_pop = fifo_valid & (remaining == '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending <= '0;
    end else if (fifo_pop) begin
      pending <= TAG_ENABLE;
    end else begin
      pending <= remaining;
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_pop) begin
      data_q <= fifo_data;
    end
  end

  assign bcast_valid = pending;
  assign bcast_data = data_q;

endmodule

`default_nettype wire

/* source/xcorr_pkg.sv */
// cross-correlation front end
// shared widths and tag templates

`default_nettype none

package xcorr_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sample and result widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int SAMPLE_WIDTH = 16;
  localparam int TAPS = 4;
  localparam int MAX_TAGS = 8;

  // growth bits for TAPS signed additions
  localparam int RESULT_WIDTH = SAMPLE_WIDTH + $clog2(TAPS);

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
  typedef logic signed [RESULT_WIDTH-1:0] result_t;

  // one bit per tag that has a template row
  typedef logic [MAX_TAGS-1:0] tag_mask_t;

  ////////////////////////////////////////////////////////////////////////////
  // sign templates, bit set means subtract, tap 0 is the newest sample
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [MAX_TAGS-1:0][TAPS-1:0] tag_templates = '{
    0: 4'b0000,
    1: 4'b0101,
    2: 4'b0011,
    3: 4'b0110,
    4: 4'b1001,
    5: 4'b1010,
    6: 4'b1100,
    7: 4'b1110
  };

endpackage

`default_nettype wire

/* source/xcorr_tag.sv */
// single-tag sign correlator

`timescale 1ns/1ps
`default_nettype none

module xcorr_tag #(
  parameter int TAG_INDEX = 0
) (
  input  logic               clk,
  input  logic               rst_n,

  input  logic               s_valid,
  output logic               s_ready,
  input  xcorr_pkg::sample_t s_data,

  output logic               m_valid,
  input  logic               m_ready,
  output xcorr_pkg::result_t m_data
);

  localparam int TAPS = xcorr_pkg::TAPS;
  localparam logic [TAPS-1:0] SIGNS = xcorr_pkg::tag_templates[TAG_INDEX];

  xcorr_pkg::sample_t window [TAPS];
  xcorr_pkg::sample_t win_next [TAPS];
  xcorr_pkg::result_t sum;
  xcorr_pkg::result_t term;
  logic               take;

  // output register empty or draining this cycle
  assign s_ready = ~m_valid | m_ready;
  assign take = s_valid & s_ready;

  ////////////////////////////////////////////////////////////////////////////
  // window as it will be after this sample, and its signed sum
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    win_next[0] = s_data;
    for (int i = 1; i < TAPS; i++) begin
      win_next[i] = window[i-1];
    end
  end

  always_comb begin
    sum = '0;
    for (int i = 0; i < TAPS; i++) begin
      term = xcorr_pkg::result_t'(win_next[i]);
      if (SIGNS[i]) begin
        sum = sum - term;
      end else begin
        sum = sum + term;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // state
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < TAPS; i++) begin
        window[i] <= '0;
      end
    end else if (take) begin
      window <= win_next;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m_valid <= 1'b0;
    end else if (take) begin
      m_valid <= 1'b1;
    end else if (m_ready) begin
      m_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      m_data <= sum;
    end
  end

endmodule

`default_nettype wire

/* source/xcorr_top.sv */
// multi-tag cross-correlation front end

`timescale 1ns/1ps
`default_nettype none

module xcorr_top #(
  parameter int                  NUM_TAGS = 4,
  parameter int                  FIFO_DEPTH = 16,
  parameter logic [NUM_TAGS-1:0] TAG_ENABLE = '1
) (
  input  logic                               in_clk,
  input  logic                               clk,
  input  logic                               rst_n,

  input  logic                               s_valid,
  output logic                               s_ready,
  input  xcorr_pkg::sample_t                 s_data,

  output logic [NUM_TAGS-1:0]                m_valid,
  input  logic [NUM_TAGS-1:0]                m_ready,
  output xcorr_pkg::result_t [NUM_TAGS-1:0]  m_data
);

  // enable bits widened to the template table
  localparam xcorr_pkg::tag_mask_t ENABLE_MASK = xcorr_pkg::tag_mask_t'(TAG_ENABLE);

  logic                fifo_valid;
  logic                fifo_pop;
  xcorr_pkg::sample_t  fifo_data;
  logic [NUM_TAGS-1:0] bcast_valid;
  logic [NUM_TAGS-1:0] bcast_ready;
  xcorr_pkg::sample_t  bcast_data;

  sample_fifo_async #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) sample_fifo_i (
    .in_clk   (in_clk),
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_valid (s_valid),
    .wr_ready (s_ready),
    .wr_data  (s_data),
    .rd_valid (fifo_valid),
    .rd_pop   (fifo_pop),
    .rd_data  (fifo_data)
  );

  xcorr_fanout_ctrl #(
    .NUM_TAGS   (NUM_TAGS),
    .TAG_ENABLE (ENABLE_MASK[NUM_TAGS-1:0])
  ) fanout_ctrl_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .fifo_valid  (fifo_valid),
    .fifo_pop    (fifo_pop),
    .fifo_data   (fifo_data),
    .bcast_valid (bcast_valid),
    .bcast_ready (bcast_ready),
    .bcast_data  (bcast_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // tag bank
  ////////////////////////////////////////////////////////////////////////////

  for (genvar t = 0; t < NUM_TAGS; t++) begin : g_tag
    if (ENABLE_MASK[t]) begin : g_on
      xcorr_tag #(
        .TAG_INDEX (t)
      ) xcorr_tag_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .s_valid (bcast_valid[t]),
        .s_ready (bcast_ready[t]),
        .s_data  (bcast_data),
        .m_valid (m_valid[t]),
        .m_ready (m_ready[t]),
        .m_data  (m_data[t])
      );
    end else begin : g_off
      // never pending in the control module
      assign bcast_ready[t] = 1'b1;
      assign m_valid[t] = 1'b0;
      assign m_data[t] = '0;
    end
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+sim
source/xcorr_pkg.sv
source/sample_fifo_async.sv
source/xcorr_fanout_ctrl.sv
source/xcorr_tag.sv
source/xcorr_top.sv
sim/tb_xcorr.sv
